// File: compile.f
source/mmu_pkg.sv
source/line_cache.sv
source/bus_arbiter.sv
source/axi_master_port.sv
source/mmu_axi.sv
tb/axi_mem_slave.sv
tb/mmu_axi_assert.sv
tb/tb_mmu_axi.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mmu_axi testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_mmu_axi \
    -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" <<< "$out"; then
    exit 0
fi
exit 1

// File: source/axi_master_port.sv
`timescale 1ns/1ns

module axi_master_port
    import mmu_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,

    input  logic              job_valid,
    input  job_e              job_kind,
    input  logic [ADDR_W-1:0] job_addr,
    input  logic [DATA_W-1:0] job_data,
    output logic              job_ready,
    output logic              job_done,
    output logic              beat_valid,
    output logic [DATA_W-1:0] beat_data,

    output logic [ADDR_W-1:0] ARADDR,
    output logic [LEN_W-1:0]  ARLEN,
    output logic              ARVALID,
    input  logic              ARREADY,
    input  logic [DATA_W-1:0] RDATA,
    input  logic              RLAST,
    input  logic              RVALID,
    output logic              RREADY,

    output logic [ADDR_W-1:0] AWADDR,
    output logic [LEN_W-1:0]  AWLEN,
    output logic              AWVALID,
    input  logic              AWREADY,
    output logic [DATA_W-1:0] WDATA,
    output logic [STRB_W-1:0] WSTRB,
    output logic              WLAST,
    output logic              WVALID,
    input  logic              WREADY,
    input  logic              BVALID,
    output logic              BREADY
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_AR,
        P_R,
        P_AW_W,
        P_B
    } port_state_e;

    port_state_e       state;
    logic [ADDR_W-1:0] addr_q;
    logic              aw_left;
    logic              w_left;

    assign job_ready  = (state == P_IDLE);
    assign RREADY     = (state == P_R);
    assign BREADY     = (state == P_B);
    assign beat_valid = RVALID && RREADY;
    assign beat_data  = RDATA;
    assign job_done   = (beat_valid && RLAST) || (BVALID && BREADY);

    assign ARADDR  = addr_q;
    assign ARLEN   = LEN_W'(BURST_LEN);
    assign ARVALID = (state == P_AR);

    // single full-word beat per store
    assign AWADDR  = addr_q;
    assign AWLEN   = '0;
    assign AWVALID = (state == P_AW_W) && aw_left;
    assign WSTRB   = '1;
    assign WLAST   = 1'b1;
    assign WVALID  = (state == P_AW_W) && w_left;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state   <= P_IDLE;
            aw_left <= 1'b0;
            w_left  <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (job_valid) begin
                        if (job_kind == JOB_STORE) begin
                            state   <= P_AW_W;
                            aw_left <= 1'b1;
                            w_left  <= 1'b1;
                        end else begin
                            state <= P_AR;
                        end
                    end
                end
                P_AR: begin
                    if (ARREADY)
                        state <= P_R;
                end
                P_R: begin
                    if (RVALID && RLAST)
                        state <= P_IDLE;
                end
                P_AW_W: begin
                    // AW and W complete in either order
                    if (AWREADY)
                        aw_left <= 1'b0;
                    if (WREADY)
                        w_left <= 1'b0;
                    if ((!aw_left || AWREADY) && (!w_left || WREADY))
                        state <= P_B;
                end
                P_B: begin
                    if (BVALID)
                        state <= P_IDLE;
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (job_valid && job_ready) begin
            addr_q <= job_addr;
            WDATA  <= job_data;
        end
    end

endmodule

// File: source/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter
    import mmu_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,

    input  logic              inst_fill_valid,
    input  logic [ADDR_W-1:0] inst_fill_addr,
    output logic              inst_fill_ready,
    output logic              inst_beat_valid,
    output logic              inst_fill_done,

    input  logic              data_fill_valid,
    input  logic [ADDR_W-1:0] data_fill_addr,
    output logic              data_fill_ready,
    output logic              data_beat_valid,
    output logic              data_fill_done,

    input  logic              store_wren,
    input  logic [ADDR_W-1:0] store_addr,
    input  logic [DATA_W-1:0] store_data,
    output logic              store_busy,

    output logic              job_valid,
    output job_e              job_kind,
    output logic [ADDR_W-1:0] job_addr,
    output logic [DATA_W-1:0] job_data,
    input  logic              job_ready,
    input  logic              job_done,
    input  logic              beat_valid
);

    job_e              grant;
    job_e              grant_next;
    logic              store_pend;
    logic              store_hold;
    logic              store_take;
    logic              store_done;
    logic [ADDR_W-1:0] store_addr_q;

    assign job_kind = grant;

    // inst refill, then data refill, then the buffered store
    always_comb begin
        grant_next = grant;
        case (grant)
            JOB_NONE: begin
                if (inst_fill_valid)
                    grant_next = JOB_INST;
                else if (data_fill_valid)
                    grant_next = JOB_DATA;
                else if (store_pend)
                    grant_next = JOB_STORE;
            end
            default: begin
                if (job_done)
                    grant_next = JOB_NONE;
            end
        endcase
    end

    assign inst_fill_ready = (grant == JOB_NONE) && (grant_next == JOB_INST);
    assign data_fill_ready = (grant == JOB_NONE) && (grant_next == JOB_DATA);

    assign inst_beat_valid = beat_valid && (grant == JOB_INST);
    assign data_beat_valid = beat_valid && (grant == JOB_DATA);
    assign inst_fill_done  = job_done && (grant == JOB_INST);
    assign data_fill_done  = job_done && (grant == JOB_DATA);

    // hold masks the still-asserted wren for the cycle after B
    assign store_done = job_done && (grant == JOB_STORE);
    assign store_take = store_wren && !store_pend && !store_hold;
    assign store_busy = store_pend || (store_wren && !store_hold);

    always_ff @(posedge CLK) begin
        if (RST) begin
            grant      <= JOB_NONE;
            job_valid  <= 1'b0;
            store_pend <= 1'b0;
            store_hold <= 1'b0;
        end else begin
            grant <= grant_next;

            if (grant == JOB_NONE && grant_next != JOB_NONE)
                job_valid <= 1'b1;
            else if (job_ready)
                job_valid <= 1'b0;

            if (store_take)
                store_pend <= 1'b1;
            else if (store_done)
                store_pend <= 1'b0;
            store_hold <= store_done;
        end
    end

    always_ff @(posedge CLK) begin
        if (store_take) begin
            store_addr_q <= store_addr;
            job_data     <= store_data;
        end

        if (grant == JOB_NONE) begin
            case (grant_next)
                JOB_INST:  job_addr <= inst_fill_addr;
                JOB_DATA:  job_addr <= data_fill_addr;
                JOB_STORE: job_addr <= store_addr_q;
                default:   job_addr <= job_addr;
            endcase
        end
    end

endmodule

// File: source/line_cache.sv
`timescale 1ns/1ns

module line_cache
    import mmu_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,

    input  logic              rden,
    input  logic [ADDR_W-1:0] raddr,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,
    output logic [ADDR_W-1:0] roaddr,
    output logic              miss,

    output logic              fill_valid,
    output logic [ADDR_W-1:0] fill_addr,
    input  logic              fill_ready,
    input  logic              fill_beat_valid,
    input  logic [DATA_W-1:0] fill_beat_data,
    input  logic              fill_done,

    input  logic              snoop_wren,
    input  logic [ADDR_W-1:0] snoop_addr,
    input  logic [DATA_W-1:0] snoop_data
);

    logic [TAG_W-1:0]    tag_mem  [LINES];
    logic [DATA_W-1:0]   data_mem [LINES*LINE_WORDS];
    logic [LINES-1:0]    line_ok;

    logic [INDEX_W-1:0]  r_index;
    logic [OFFSET_W-1:0] r_offset;
    logic [TAG_W-1:0]    r_tag;
    logic                hit;

    logic [INDEX_W-1:0]  s_index;
    logic [OFFSET_W-1:0] s_offset;
    logic [TAG_W-1:0]    s_tag;
    logic                snoop_hit;

    logic                filling;
    logic                fill_take;
    logic [INDEX_W-1:0]  fill_index;
    logic [OFFSET_W-1:0] beat_cnt;

    assign r_offset = raddr[BYTE_W +: OFFSET_W];
    assign r_index  = raddr[BYTE_W+OFFSET_W +: INDEX_W];
    assign r_tag    = raddr[ADDR_W-1 -: TAG_W];

    assign hit  = rden && line_ok[r_index] && (tag_mem[r_index] == r_tag);
    assign miss = rden && !hit;

    assign s_offset  = snoop_addr[BYTE_W +: OFFSET_W];
    assign s_index   = snoop_addr[BYTE_W+OFFSET_W +: INDEX_W];
    assign s_tag     = snoop_addr[ADDR_W-1 -: TAG_W];
    assign snoop_hit = snoop_wren && line_ok[s_index] && (tag_mem[s_index] == s_tag);

    // one refill at a time, request drops once accepted
    assign fill_valid = miss && !filling;
    assign fill_take  = fill_valid && fill_ready;
    assign fill_addr  = {raddr[ADDR_W-1:BYTE_W+OFFSET_W], {(OFFSET_W+BYTE_W){1'b0}}};

    always_ff @(posedge CLK) begin
        if (RST) begin
            line_ok <= '0;
            filling <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rvalid <= hit;
            if (fill_take) begin
                // line stays invalid until the last beat lands
                filling          <= 1'b1;
                line_ok[r_index] <= 1'b0;
            end else if (fill_done) begin
                filling             <= 1'b0;
                line_ok[fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (hit) begin
            rdata  <= data_mem[{r_index, r_offset}];
            roaddr <= raddr;
        end

        if (fill_take) begin
            fill_index       <= r_index;
            tag_mem[r_index] <= r_tag;
            beat_cnt         <= '0;
        end

        // beats first; a held store snoops again on a later cycle
        if (fill_beat_valid) begin
            data_mem[{fill_index, beat_cnt}] <= fill_beat_data;
            beat_cnt                         <= beat_cnt + 1'b1;
        end else if (snoop_hit) begin
            data_mem[{s_index, s_offset}] <= snoop_data;
        end
    end

endmodule

// File: source/mmu_axi.sv
`timescale 1ns/1ns

module mmu_axi
    import mmu_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,
    output logic              mem_wait,

    input  logic              inst_rden,
    input  logic [ADDR_W-1:0] inst_raddr,
    output logic [ADDR_W-1:0] inst_roaddr,
    output logic              inst_rvalid,
    output logic [DATA_W-1:0] inst_rdata,

    input  logic              data_rden,
    input  logic [ADDR_W-1:0] data_raddr,
    output logic [ADDR_W-1:0] data_roaddr,
    output logic              data_rvalid,
    output logic [DATA_W-1:0] data_rdata,
    input  logic              data_wren,
    input  logic [ADDR_W-1:0] data_waddr,
    input  logic [DATA_W-1:0] data_wdata,

    output logic [ADDR_W-1:0] ARADDR,
    output logic [LEN_W-1:0]  ARLEN,
    output logic              ARVALID,
    input  logic              ARREADY,
    input  logic [DATA_W-1:0] RDATA,
    input  logic              RLAST,
    input  logic              RVALID,
    output logic              RREADY,
    output logic [ADDR_W-1:0] AWADDR,
    output logic [LEN_W-1:0]  AWLEN,
    output logic              AWVALID,
    input  logic              AWREADY,
    output logic [DATA_W-1:0] WDATA,
    output logic [STRB_W-1:0] WSTRB,
    output logic              WLAST,
    output logic              WVALID,
    input  logic              WREADY,
    input  logic              BVALID,
    output logic              BREADY
);

    logic              inst_miss;
    logic              inst_fill_valid;
    logic [ADDR_W-1:0] inst_fill_addr;
    logic              inst_fill_ready;
    logic              inst_beat_valid;
    logic              inst_fill_done;

    logic              data_miss;
    logic              data_fill_valid;
    logic [ADDR_W-1:0] data_fill_addr;
    logic              data_fill_ready;
    logic              data_beat_valid;
    logic              data_fill_done;

    logic              store_busy;
    logic              job_valid;
    job_e              job_kind;
    logic [ADDR_W-1:0] job_addr;
    logic [DATA_W-1:0] job_data;
    logic              job_ready;
    logic              job_done;
    logic              beat_valid;
    logic [DATA_W-1:0] beat_data;

    // pipeline waits on any open miss or store
    assign mem_wait = inst_miss || data_miss || store_busy;

    // stores snoop both caches so written code reads back new
    line_cache inst_cache (
        .CLK             (CLK),
        .RST             (RST),
        .rden            (inst_rden),
        .raddr           (inst_raddr),
        .rvalid          (inst_rvalid),
        .rdata           (inst_rdata),
        .roaddr          (inst_roaddr),
        .miss            (inst_miss),
        .fill_valid      (inst_fill_valid),
        .fill_addr       (inst_fill_addr),
        .fill_ready      (inst_fill_ready),
        .fill_beat_valid (inst_beat_valid),
        .fill_beat_data  (beat_data),
        .fill_done       (inst_fill_done),
        .snoop_wren      (data_wren),
        .snoop_addr      (data_waddr),
        .snoop_data      (data_wdata)
    );

    line_cache data_cache (
        .CLK             (CLK),
        .RST             (RST),
        .rden            (data_rden),
        .raddr           (data_raddr),
        .rvalid          (data_rvalid),
        .rdata           (data_rdata),
        .roaddr          (data_roaddr),
        .miss            (data_miss),
        .fill_valid      (data_fill_valid),
        .fill_addr       (data_fill_addr),
        .fill_ready      (data_fill_ready),
        .fill_beat_valid (data_beat_valid),
        .fill_beat_data  (beat_data),
        .fill_done       (data_fill_done),
        .snoop_wren      (data_wren),
        .snoop_addr      (data_waddr),
        .snoop_data      (data_wdata)
    );

    bus_arbiter bus_arbiter (
        .CLK             (CLK),
        .RST             (RST),
        .inst_fill_valid (inst_fill_valid),
        .inst_fill_addr  (inst_fill_addr),
        .inst_fill_ready (inst_fill_ready),
        .inst_beat_valid (inst_beat_valid),
        .inst_fill_done  (inst_fill_done),
        .data_fill_valid (data_fill_valid),
        .data_fill_addr  (data_fill_addr),
        .data_fill_ready (data_fill_ready),
        .data_beat_valid (data_beat_valid),
        .data_fill_done  (data_fill_done),
        .store_wren      (data_wren),
        .store_addr      (data_waddr),
        .store_data      (data_wdata),
        .store_busy      (store_busy),
        .job_valid       (job_valid),
        .job_kind        (job_kind),
        .job_addr        (job_addr),
        .job_data        (job_data),
        .job_ready       (job_ready),
        .job_done        (job_done),
        .beat_valid      (beat_valid)
    );

    axi_master_port axi_master_port (
        .CLK        (CLK),
        .RST        (RST),
        .job_valid  (job_valid),
        .job_kind   (job_kind),
        .job_addr   (job_addr),
        .job_data   (job_data),
        .job_ready  (job_ready),
        .job_done   (job_done),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .ARADDR     (ARADDR),
        .ARLEN      (ARLEN),
        .ARVALID    (ARVALID),
        .ARREADY    (ARREADY),
        .RDATA      (RDATA),
        .RLAST      (RLAST),
        .RVALID     (RVALID),
        .RREADY     (RREADY),
        .AWADDR     (AWADDR),
        .AWLEN      (AWLEN),
        .AWVALID    (AWVALID),
        .AWREADY    (AWREADY),
        .WDATA      (WDATA),
        .WSTRB      (WSTRB),
        .WLAST      (WLAST),
        .WVALID     (WVALID),
        .WREADY     (WREADY),
        .BVALID     (BVALID),
        .BREADY     (BREADY)
    );

endmodule

// File: source/mmu_pkg.sv
package mmu_pkg;

    // bus and word geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 2;
    localparam int STRB_W     = DATA_W / 8;

    // direct-mapped cache, 16 lines of 4 words
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 2;
    localparam int INDEX_W    = 4;
    localparam int LINES      = 1 << INDEX_W;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

    // AXI length field and refill burst
    localparam int LEN_W      = 8;
    localparam int BURST_LEN  = LINE_WORDS - 1;

    typedef enum logic [1:0] {
        JOB_NONE,
        JOB_INST,
        JOB_DATA,
        JOB_STORE
    } job_e;

endpackage

// File: tb/axi_mem_slave.sv
`timescale 1ns/1ns

module axi_mem_slave
    import mmu_pkg::*;
(
    input  logic              CLK,
    input  logic              RST,
    input  logic [ADDR_W-1:0] ARADDR,
    input  logic [LEN_W-1:0]  ARLEN,
    input  logic              ARVALID,
    output logic              ARREADY,
    output logic [DATA_W-1:0] RDATA,
    output logic              RLAST,
    output logic              RVALID,
    input  logic              RREADY,
    input  logic [ADDR_W-1:0] AWADDR,
    input  logic              AWVALID,
    output logic              AWREADY,
    input  logic [DATA_W-1:0] WDATA,
    input  logic              WVALID,
    output logic              WREADY,
    output logic              BVALID,
    input  logic              BREADY
);

    logic [DATA_W-1:0] mem [1024];
    logic              filled = 1'b0;
    logic              rd_busy;
    logic [9:0]        rd_idx;
    logic [LEN_W-1:0]  rd_left;
    logic              aw_got;
    logic              w_got;
    logic [9:0]        wr_idx;
    logic [DATA_W-1:0] wr_data;

    always @(posedge CLK) begin
        if (RST) begin
            // random contents, loaded once during the first reset cycle
            if (!filled) begin
                for (int i = 0; i < 1024; i++)
                    mem[i] <= $urandom;
                filled <= 1'b1;
            end
            ARREADY <= 1'b0;
            RVALID  <= 1'b0;
            RLAST   <= 1'b0;
            AWREADY <= 1'b0;
            WREADY  <= 1'b0;
            BVALID  <= 1'b0;
            rd_busy <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            if (ARVALID && ARREADY) begin
                rd_busy <= 1'b1;
                rd_idx  <= ARADDR[11:2];
                rd_left <= ARLEN;
                ARREADY <= 1'b0;
            end else begin
                ARREADY <= !rd_busy && ($urandom_range(3) != 0);
            end

            if (rd_busy) begin
                if (RVALID && RREADY) begin
                    RVALID  <= 1'b0;
                    RLAST   <= 1'b0;
                    rd_idx  <= rd_idx + 10'd1;
                    rd_left <= rd_left - 1'b1;
                    if (RLAST)
                        rd_busy <= 1'b0;
                end else if (!RVALID && ($urandom_range(3) != 0)) begin
                    RVALID <= 1'b1;
                    RDATA  <= mem[rd_idx];
                    RLAST  <= (rd_left == 0);
                end
            end

            // AW and W are taken independently
            if (AWVALID && AWREADY) begin
                aw_got  <= 1'b1;
                wr_idx  <= AWADDR[11:2];
                AWREADY <= 1'b0;
            end else begin
                AWREADY <= !aw_got && ($urandom_range(3) != 0);
            end
            if (WVALID && WREADY) begin
                w_got   <= 1'b1;
                wr_data <= WDATA;
                WREADY  <= 1'b0;
            end else begin
                WREADY <= !w_got && ($urandom_range(3) != 0);
            end

            if (aw_got && w_got && !BVALID) begin
                mem[wr_idx] <= wr_data;
                BVALID      <= 1'b1;
            end
            if (BVALID && BREADY) begin
                BVALID <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

endmodule

// File: tb/mmu_axi_assert.sv
`timescale 1ns/1ns

module mmu_axi_assert
    import mmu_pkg::*;
(
    input logic              CLK,
    input logic              RST,
    input logic              ARVALID,
    input logic              ARREADY,
    input logic [ADDR_W-1:0] ARADDR,
    input logic              RVALID,
    input logic              RREADY,
    input logic              RLAST,
    input logic              AWVALID,
    input logic              AWREADY,
    input logic [ADDR_W-1:0] AWADDR,
    input logic              WVALID,
    input logic              WREADY,
    input logic [DATA_W-1:0] WDATA,
    input logic              BVALID,
    input logic              BREADY
);

    logic [2:0] r_beats;
    logic       wr_open;

    always_ff @(posedge CLK) begin
        if (RST) begin
            r_beats <= '0;
            wr_open <= 1'b0;
        end else begin
            if (RVALID && RREADY)
                r_beats <= RLAST ? 3'd0 : r_beats + 3'd1;
            if (AWVALID)
                wr_open <= 1'b1;
            else if (BVALID && BREADY)
                wr_open <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge CLK) disable iff (RST)
        ARVALID && !ARREADY |=> ARVALID && $stable(ARADDR))
        else $error("ARVALID or ARADDR changed before the AR transfer");

    aw_stable: assert property (@(posedge CLK) disable iff (RST)
        AWVALID && !AWREADY |=> AWVALID && $stable(AWADDR))
        else $error("AWVALID or AWADDR changed before the AW transfer");

    w_stable: assert property (@(posedge CLK) disable iff (RST)
        WVALID && !WREADY |=> WVALID && $stable(WDATA))
        else $error("WVALID or WDATA changed before the W transfer");

    // last beat is the fourth
    rlast_fourth: assert property (@(posedge CLK) disable iff (RST)
        RVALID && RREADY |-> (RLAST == (r_beats == 3'd3)))
        else $error("RLAST not on the fourth beat of a refill");

    no_read_in_write: assert property (@(posedge CLK) disable iff (RST)
        !(ARVALID && wr_open))
        else $error("AR request issued while a write is outstanding");

endmodule

bind mmu_axi mmu_axi_assert axi_checks (
    .CLK     (CLK),
    .RST     (RST),
    .ARVALID (ARVALID),
    .ARREADY (ARREADY),
    .ARADDR  (ARADDR),
    .RVALID  (RVALID),
    .RREADY  (RREADY),
    .RLAST   (RLAST),
    .AWVALID (AWVALID),
    .AWREADY (AWREADY),
    .AWADDR  (AWADDR),
    .WVALID  (WVALID),
    .WREADY  (WREADY),
    .WDATA   (WDATA),
    .BVALID  (BVALID),
    .BREADY  (BREADY)
);

// File: tb/tb_mmu_axi.sv
`timescale 1ns/1ns

module tb_mmu_axi
    import mmu_pkg::*;
;

    localparam int SEED       = 62;
    localparam int N_READS    = 40;
    localparam int N_STORES   = 10;
    localparam int N_PAIRS    = 4;
    localparam int N_MIXED    = 60;
    localparam int TOTAL_OPS  = 4 * N_READS + 5 * N_STORES + 4 * N_PAIRS + N_MIXED;
    localparam int OP_CYCLES  = 64;

    logic              CLK;
    logic              RST;
    logic              mem_wait;
    logic              inst_rden;
    logic [ADDR_W-1:0] inst_raddr;
    logic [ADDR_W-1:0] inst_roaddr;
    logic              inst_rvalid;
    logic [DATA_W-1:0] inst_rdata;
    logic              data_rden;
    logic [ADDR_W-1:0] data_raddr;
    logic [ADDR_W-1:0] data_roaddr;
    logic              data_rvalid;
    logic [DATA_W-1:0] data_rdata;
    logic              data_wren;
    logic [ADDR_W-1:0] data_waddr;
    logic [DATA_W-1:0] data_wdata;

    logic [ADDR_W-1:0] ARADDR;
    logic [LEN_W-1:0]  ARLEN;
    logic              ARVALID;
    logic              ARREADY;
    logic [DATA_W-1:0] RDATA;
    logic              RLAST;
    logic              RVALID;
    logic              RREADY;
    logic [ADDR_W-1:0] AWADDR;
    logic [LEN_W-1:0]  AWLEN;
    logic              AWVALID;
    logic              AWREADY;
    logic [DATA_W-1:0] WDATA;
    logic [STRB_W-1:0] WSTRB;
    logic              WLAST;
    logic              WVALID;
    logic              WREADY;
    logic              BVALID;
    logic              BREADY;

    logic [DATA_W-1:0] model [1024];
    logic [ADDR_W-1:0] ar_log [$];
    int                errors = 0;
    int                tests  = 0;
    int                test_start_errors = 0;
    int                aw_count = 0;
    int                w_count = 0;
    int                beat_cnt = 0;
    logic [ADDR_W-1:0] last_awaddr;
    logic [DATA_W-1:0] last_wdata;
    logic [STRB_W-1:0] last_wstrb;

    mmu_axi DUT (.*);

    axi_mem_slave mem_slave (
        .CLK(CLK), .RST(RST),
        .ARADDR(ARADDR), .ARLEN(ARLEN), .ARVALID(ARVALID), .ARREADY(ARREADY),
        .RDATA(RDATA), .RLAST(RLAST), .RVALID(RVALID), .RREADY(RREADY),
        .AWADDR(AWADDR), .AWVALID(AWVALID), .AWREADY(AWREADY),
        .WDATA(WDATA), .WVALID(WVALID), .WREADY(WREADY),
        .BVALID(BVALID), .BREADY(BREADY)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    function automatic logic [ADDR_W-1:0] rand_addr();
        return {20'h0, 10'($urandom_range(1023)), 2'b00};
    endfunction

    // bus monitor counting transfers and checking each burst
    always @(posedge CLK) begin
        if (!RST) begin
            if (ARVALID && ARREADY) begin
                ar_log.push_back(ARADDR);
                if (ARADDR[3:0] != 4'h0)
                    report_mismatch("ARADDR[3:0]", 32'(ARADDR[3:0]), 32'h0);
                if (ARLEN != LEN_W'(3))
                    report_mismatch("ARLEN", 32'(ARLEN), 32'h3);
            end
            if (RVALID && !RREADY)
                report_error("RVALID is high while RREADY is low");
            if (RVALID && RREADY) begin
                beat_cnt = beat_cnt + 1;
                if (RLAST) begin
                    if (beat_cnt != 4)
                        report_mismatch("R beats", 32'(beat_cnt), 32'h4);
                    beat_cnt = 0;
                end
            end
            if (AWVALID && AWREADY) begin
                aw_count++;
                last_awaddr = AWADDR;
                if (AWLEN !== '0)
                    report_mismatch("AWLEN", 32'(AWLEN), 32'h0);
            end
            if (WVALID && WREADY) begin
                w_count++;
                last_wdata = WDATA;
                last_wstrb = WSTRB;
                if (WLAST !== 1'b1)
                    report_mismatch("WLAST", 32'(WLAST), 32'h1);
            end
            if (BVALID && !BREADY)
                report_error("BVALID is high while BREADY is low");
        end
    end

    task automatic read_word(input bit is_inst, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] exp;
        exp = model[addr[11:2]];
        if (is_inst) begin
            inst_rden  = 1'b1;
            inst_raddr = addr;
        end else begin
            data_rden  = 1'b1;
            data_raddr = addr;
        end
        do begin
            @(posedge CLK);
            #1;
        end while (!(is_inst ? inst_rvalid : data_rvalid));
        if (is_inst) begin
            if (inst_rdata !== exp)
                report_mismatch("inst_rdata", inst_rdata, exp);
            if (inst_roaddr !== addr)
                report_mismatch("inst_roaddr", inst_roaddr, addr);
            inst_rden = 1'b0;
        end else begin
            if (data_rdata !== exp)
                report_mismatch("data_rdata", data_rdata, exp);
            if (data_roaddr !== addr)
                report_mismatch("data_roaddr", data_roaddr, addr);
            data_rden = 1'b0;
        end
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        model[addr[11:2]] = data;
        data_wren  = 1'b1;
        data_waddr = addr;
        data_wdata = data;
        do begin
            @(posedge CLK);
            #1;
        end while (mem_wait);
        data_wren = 1'b0;
    endtask

    // repeat inside the same line must not refill
    task automatic read_lines(input bit is_inst);
        logic [ADDR_W-1:0] addr;
        int                ar_before;
        for (int i = 0; i < N_READS; i++) begin
            addr = rand_addr();
            read_word(is_inst, addr);
            ar_before = ar_log.size();
            read_word(is_inst, {addr[31:4], 2'($urandom_range(3)), 2'b00});
            if (ar_log.size() != ar_before)
                report_mismatch("AR transfers", 32'(ar_log.size()), 32'(ar_before));
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] addr_b;
        logic [DATA_W-1:0] data;
        int                aw_before;
        int                w_before;
        int                ar_before;
        void'($urandom(SEED));
        RST        = 1'b1;
        inst_rden  = 1'b0;
        inst_raddr = '0;
        data_rden  = 1'b0;
        data_raddr = '0;
        data_wren  = 1'b0;
        data_waddr = '0;
        data_wdata = '0;
        repeat (2) @(posedge CLK);
        #1;
        RST = 1'b0;
        for (int i = 0; i < 1024; i++)
            model[i] = mem_slave.mem[i];

        if (mem_wait !== 1'b0)
            report_error("mem_wait is high after reset");
        if (inst_rvalid !== 1'b0 || data_rvalid !== 1'b0)
            report_error("an rvalid is high after reset");
        if (ARVALID !== 1'b0 || AWVALID !== 1'b0 || WVALID !== 1'b0)
            report_error("an AXI valid is high after reset");
        finish_test("reset");

        read_lines(1'b1);
        finish_test("inst reads");
        read_lines(1'b0);
        finish_test("data reads");

        for (int i = 0; i < N_STORES; i++) begin
            addr = rand_addr();
            data = $urandom;
            // cached copies in both sides exercise the snoop
            read_word(1'b1, addr);
            read_word(1'b0, addr);
            aw_before = aw_count;
            w_before  = w_count;
            store_word(addr, data);
            if (aw_count != aw_before + 1)
                report_mismatch("AW transfers", 32'(aw_count - aw_before), 32'h1);
            if (w_count != w_before + 1)
                report_mismatch("W transfers", 32'(w_count - w_before), 32'h1);
            if (last_awaddr !== addr)
                report_mismatch("AWADDR", last_awaddr, addr);
            if (last_wdata !== data)
                report_mismatch("WDATA", last_wdata, data);
            if (last_wstrb !== 4'hf)
                report_mismatch("WSTRB", 32'(last_wstrb), 32'hf);
            read_word(1'b0, addr);
            read_word(1'b1, addr);
        end
        finish_test("stores");

        for (int i = 0; i < N_PAIRS; i++) begin
            addr   = rand_addr();
            addr_b = rand_addr();
            // conflicting tags evict both target lines first
            read_word(1'b1, addr ^ 32'h800);
            read_word(1'b0, addr_b ^ 32'h800);
            ar_before = ar_log.size();
            fork
                read_word(1'b1, addr);
                read_word(1'b0, addr_b);
            join
            if (ar_log.size() <= ar_before)
                report_error("no refill seen for a double miss");
            else if (ar_log[ar_before] !== {addr[31:4], 4'h0})
                report_mismatch("first ARADDR", ar_log[ar_before], {addr[31:4], 4'h0});
        end
        finish_test("double miss");

        for (int i = 0; i < N_MIXED; i++) begin
            addr = rand_addr();
            case ($urandom_range(2))
                0: read_word(1'b1, addr);
                1: read_word(1'b0, addr);
                default: store_word(addr, $urandom);
            endcase
        end
        finish_test("mixed traffic");

        $display("%0d tests, %0d refills, %0d stores, %0d errors",
                 tests, ar_log.size(), aw_count, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_OPS * OP_CYCLES) @(posedge CLK);
        $display("timeout, the tests did not finish in %0d cycles", TOTAL_OPS * OP_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule
